//--- Bender.yml
package:
  name: dcache

sources:
  - hdl/dcache_pkg.sv
  - hdl/dcache_dpram.sv
  - hdl/dcache_tag_store.sv
  - hdl/dcache_way_store.sv
  - hdl/dcache_ctrl.sv
  - hdl/dcache_top.sv
  - target: simulation
    files:
      - dv/dcache_tb_clk.sv
      - dv/dcache_assert.sv
      - dv/dcache_tb.sv

//--- dv/dcache_assert.sv
// Watches only the top-level port protocol and keeps a count of failed assertions
`timescale 1ns/100ps
`default_nettype none

module dcache_assert (
   input wire clk,
   input wire rst,
   input wire cpu_ack_i,
   input wire cpu_err_i,
   input wire inv_ack_i,
   input wire refill_req_i,
   input wire refill_valid_i,
   input wire refill_err_i
);

   // Failed assertions so far
   int fail_count = 0;

   // Refill words accepted in the current refill
   logic [2:0] beat_cnt;
   // Fourth word or a bus error ends the refill
   logic       refill_end;

   always_ff @(posedge clk) begin
      if (rst || !refill_req_i) begin
         beat_cnt <= '0;
      end else if (refill_valid_i) begin
         beat_cnt <= beat_cnt + 1'b1;
      end
   end

   assign refill_end = refill_err_i || (refill_valid_i && beat_cnt == 3'd3);

   ack_err_excl: assert property (@(posedge clk) disable iff (rst) !(cpu_ack_i && cpu_err_i))
      else begin
         $error("cpu_ack_o and cpu_err_o are high together");
         fail_count++;
      end

   inv_ack_pulse: assert property (@(posedge clk) disable iff (rst) inv_ack_i |=> !inv_ack_i)
      else begin
         $error("inv_ack_o is high for more than one cycle");
         fail_count++;
      end

   // Request held until the line is complete or aborted
   refill_hold: assert property (@(posedge clk) disable iff (rst)
      refill_req_i && !refill_end |=> refill_req_i)
      else begin
         $error("refill_req_o fell before four words or a bus error");
         fail_count++;
      end

   // And dropped right after that
   refill_drop: assert property (@(posedge clk) disable iff (rst)
      refill_req_i && refill_end |=> !refill_req_i)
      else begin
         $error("refill_req_o stayed high after the refill ended");
         fail_count++;
      end

   reset_quiet: assert property (@(posedge clk)
      rst |=> !(cpu_ack_i || cpu_err_i || refill_req_i || inv_ack_i))
      else begin
         $error("a control output is high in the cycle after rst");
         fail_count++;
      end

endmodule

`default_nettype wire

//--- dv/dcache_tb.sv
// Single outstanding CPU request, and the external store always answers refills from word 0
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;

   // Watchdog budget per issued request, margin covers the tag clear sweep
   localparam int WD_CYCLES_PER_REQ = 400;
   localparam int WD_MARGIN         = 200;
   // Request cycle plus the acking cycle
   localparam int HIT_LATENCY       = 2;
   localparam int LINE_WORDS        = 2 ** dcache_pkg::WORD_SEL_W;

   logic clk;
   logic rst;

   // CPU port
   logic                 cpu_req;
   logic                 cpu_we;
   dcache_pkg::addr_t    cpu_adr;
   dcache_pkg::data_t    cpu_wdat;
   dcache_pkg::bsel_t    cpu_bsel;
   logic                 cpu_ack;
   logic                 cpu_err;
   dcache_pkg::data_t    cpu_rdat;
   // Refill port
   logic                 refill_req;
   dcache_pkg::addr_t    refill_adr;
   logic                 refill_valid;
   dcache_pkg::data_t    refill_dat;
   logic                 refill_err;
   // Invalidate port
   logic                 inv_req;
   dcache_pkg::set_idx_t inv_set;
   logic                 inv_ack;

   int mismatch_count = 0;
   int other_count    = 0;
   int req_count      = 0;
   // Refills started by the DUT and the last line base it asked for
   int refill_count   = 0;
   dcache_pkg::addr_t last_refill_adr;
   // Refill word replaced by a bus error, -1 for none
   int err_beat       = -1;
   logic [31:0] rand_state = 32'd67858;

   // External store, word-aligned keys
   dcache_pkg::data_t shadow [dcache_pkg::addr_t];

   dcache_tb_clk i_dcache_tb_clk (
      .clk (clk),
      .rst (rst)
   );

   dcache_top i_dcache_top (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req),
      .cpu_we_i       (cpu_we),
      .cpu_adr_i      (cpu_adr),
      .cpu_dat_i      (cpu_wdat),
      .cpu_bsel_i     (cpu_bsel),
      .cpu_ack_o      (cpu_ack),
      .cpu_err_o      (cpu_err),
      .cpu_dat_o      (cpu_rdat),
      .refill_req_o   (refill_req),
      .refill_adr_o   (refill_adr),
      .refill_valid_i (refill_valid),
      .refill_dat_i   (refill_dat),
      .refill_err_i   (refill_err),
      .inv_req_i      (inv_req),
      .inv_set_i      (inv_set),
      .inv_ack_o      (inv_ack)
   );

   bind dcache_top dcache_assert i_dcache_assert (
      .clk            (clk),
      .rst            (rst),
      .cpu_ack_i      (cpu_ack_o),
      .cpu_err_i      (cpu_err_o),
      .inv_ack_i      (inv_ack_o),
      .refill_req_i   (refill_req_o),
      .refill_valid_i (refill_valid_i),
      .refill_err_i   (refill_err_i)
   );

   // 32-bit LCG step
   function automatic logic [31:0] next_random();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return rand_state;
   endfunction

   // Store word, created on first touch from the LCG mixed with the address
   function automatic dcache_pkg::data_t store_word(input dcache_pkg::addr_t adr);
      dcache_pkg::addr_t key;
      key = {adr[31:2], 2'b00};
      if (!shadow.exists(key)) begin
         shadow[key] = next_random() ^ key;
      end
      return shadow[key];
   endfunction

   // Selected lanes take the new byte
   function automatic dcache_pkg::data_t merge_bytes(input dcache_pkg::data_t old_w,
                                                     input dcache_pkg::data_t new_w,
                                                     input dcache_pkg::bsel_t bsel);
      dcache_pkg::data_t res;
      for (int b = 0; b < 4; b++) begin
         res[8*b +: 8] = bsel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
      end
      return res;
   endfunction

   task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
         mismatch_count++;
      end
   endtask

   task automatic require(input bit cond, input string msg);
      assert (cond) else begin
         $display("ERROR: %s", msg);
         other_count++;
      end
   endtask

   // One CPU transfer, responses sampled on the rising edge
   task automatic cpu_access(input bit we, input dcache_pkg::addr_t adr,
                             input dcache_pkg::data_t wdat, input dcache_pkg::bsel_t bsel,
                             output dcache_pkg::data_t rdat, output bit got_err,
                             output int cycles);
      @(negedge clk);
      cpu_req  = 1'b1;
      cpu_we   = we;
      cpu_adr  = adr;
      cpu_wdat = wdat;
      cpu_bsel = bsel;
      req_count++;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (!(cpu_ack || cpu_err));
      rdat    = cpu_rdat;
      got_err = cpu_err;
      @(negedge clk);
      cpu_req  = 1'b0;
      cpu_we   = 1'b0;
      cpu_bsel = '0;
      // Response is a single-cycle pulse
      @(posedge clk);
      require(!cpu_ack && !cpu_err, "CPU response lasted longer than one cycle");
   endtask

   task automatic read_word(input string name, input dcache_pkg::addr_t adr, output int cycles);
      dcache_pkg::data_t rdat;
      bit got_err;
      cpu_access(1'b0, adr, '0, '0, rdat, got_err, cycles);
      require(!got_err, {name, ": read ended with a bus error"});
      compare_word(name, store_word(adr), rdat);
   endtask

   // Writes always reach the store and ack at once
   task automatic write_word(input string name, input dcache_pkg::addr_t adr,
                             input dcache_pkg::data_t wdat, input dcache_pkg::bsel_t bsel);
      dcache_pkg::data_t rdat;
      bit got_err;
      int cycles;
      cpu_access(1'b1, adr, wdat, bsel, rdat, got_err, cycles);
      require(!got_err, {name, ": write ended with a bus error"});
      compare_word({name, " latency"}, HIT_LATENCY, cycles);
      shadow[{adr[31:2], 2'b00}] = merge_bytes(store_word(adr), wdat, bsel);
   endtask

   task automatic read_with_error(input string name, input dcache_pkg::addr_t adr, input int beat);
      dcache_pkg::data_t rdat;
      bit got_err;
      int cycles;
      err_beat = beat;
      cpu_access(1'b0, adr, '0, '0, rdat, got_err, cycles);
      require(got_err, {name, ": refill bus error was acked instead of reported"});
   endtask

   task automatic invalidate_set(input string name, input dcache_pkg::set_idx_t set);
      int cycles;
      @(negedge clk);
      inv_req = 1'b1;
      inv_set = set;
      req_count++;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
      end while (!inv_ack);
      @(negedge clk);
      inv_req = 1'b0;
      compare_word({name, " latency"}, HIT_LATENCY, cycles);
   endtask

   // External store answering refills in order with random gaps
   always begin : refill_responder
      int gap;
      bit aborted;
      @(negedge clk);
      if (refill_req) begin
         refill_count++;
         last_refill_adr = refill_adr;
         aborted = 1'b0;
         for (int beat = 0; beat < LINE_WORDS && !aborted; beat++) begin
            gap = next_random() % 3;
            repeat (gap) @(negedge clk);
            if (beat == err_beat) begin
               refill_err = 1'b1;
               err_beat   = -1;
               aborted    = 1'b1;
            end else begin
               refill_valid = 1'b1;
               refill_dat   = store_word(refill_adr + dcache_pkg::addr_t'(4 * beat));
            end
            @(negedge clk);
            refill_valid = 1'b0;
            refill_err   = 1'b0;
            refill_dat   = '0;
         end
      end
   end

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < WD_CYCLES_PER_REQ * req_count + WD_MARGIN) begin
         @(posedge clk);
         cycles++;
      end
      $display("ERROR: watchdog expired after %0d cycles, %0d requests issued", cycles, req_count);
      $display("Simulation failed");
      $finish;
   end

   initial begin : stimulus
      int cycles;
      int refills;
      int assert_fails;
      cpu_req      = 1'b0;
      cpu_we       = 1'b0;
      cpu_adr      = '0;
      cpu_wdat     = '0;
      cpu_bsel     = '0;
      refill_valid = 1'b0;
      refill_dat   = '0;
      refill_err   = 1'b0;
      inv_req      = 1'b0;
      inv_set      = '0;
      wait (rst === 1'b0);

      // Miss fills the line from its base
      refills = refill_count;
      read_word("read miss", 32'h0000_0124, cycles);
      compare_word("read miss refills", refills + 1, refill_count);
      compare_word("refill address", 32'h0000_0120, last_refill_adr);

      // Same line hits in two cycles
      read_word("read hit", 32'h0000_012C, cycles);
      compare_word("read hit latency", HIT_LATENCY, cycles);
      compare_word("read hit refills", refills + 1, refill_count);

      // Partial write hit merges bytes
      write_word("write hit", 32'h0000_0128, 32'hA5C3_5A3C, 4'b0101);
      read_word("merged read", 32'h0000_0128, cycles);
      compare_word("merged read latency", HIT_LATENCY, cycles);
      // Write miss goes only to the store
      refills = refill_count;
      write_word("write miss", 32'h0000_0334, 32'h1234_5678, 4'b0110);
      read_word("read after write miss", 32'h0000_0334, cycles);
      compare_word("write miss allocation", refills + 1, refill_count);

      // LRU in set 4, lines A B C
      read_word("lru fill A", 32'h0000_0040, cycles);
      read_word("lru fill B", 32'h0000_1044, cycles);
      refills = refill_count;
      read_word("lru touch A", 32'h0000_0040, cycles);
      read_word("lru miss C", 32'h0000_2048, cycles);
      compare_word("lru C refills", refills + 1, refill_count);
      read_word("lru keep A", 32'h0000_004C, cycles);
      compare_word("lru A kept", refills + 1, refill_count);
      read_word("lru evict B", 32'h0000_1044, cycles);
      compare_word("lru B evicted", refills + 2, refill_count);

      // Invalidate set 8
      read_word("inv fill", 32'h0000_0580, cycles);
      read_word("inv hit", 32'h0000_0584, cycles);
      refills = refill_count;
      invalidate_set("invalidate", 4'd8);
      read_word("inv refill", 32'h0000_0580, cycles);
      compare_word("inv refills", refills + 1, refill_count);

      // Bus error on word 2 then a clean retry
      refills = refill_count;
      read_with_error("refill error", 32'h0000_07C8, 2);
      read_word("retry read", 32'h0000_07C8, cycles);
      compare_word("retry refills", refills + 2, refill_count);
      compare_word("retry address", 32'h0000_07C0, last_refill_adr);
      // Whole line came in from word 0
      for (int w = 0; w < LINE_WORDS; w++) begin
         read_word($sformatf("retry word %0d", w), 32'h0000_07C0 + 4 * w, cycles);
      end
      compare_word("retry line hits", refills + 2, refill_count);

      repeat (4) @(posedge clk);
      assert_fails = i_dcache_top.i_dcache_assert.fail_count;
      $display("Error counts: mismatches %0d, other %0d, assertions %0d",
               mismatch_count, other_count, assert_fails);
      if (mismatch_count + other_count + assert_fails == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/dcache_tb_clk.sv
// Free-running 40 ns clock from time 0 and rst held high over the first two rising edges
`timescale 1ns/100ps
`default_nettype none

module dcache_tb_clk (
   output logic clk,
   output logic rst
);

   localparam int HALF_PERIOD_NS = 20;

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD_NS) clk = ~clk;
   end

   // Release on a falling edge so no rising edge sees it change
   initial begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

//--- files.f
hdl/dcache_pkg.sv
hdl/dcache_dpram.sv
hdl/dcache_tag_store.sv
hdl/dcache_way_store.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
dv/dcache_tb_clk.sv
dv/dcache_assert.sv
dv/dcache_tb.sv

//--- hdl/dcache_ctrl.sv
// Serves one request at a time and relies on the CPU and invalidate requester holding their fields
`timescale 1ns/100ps
`default_nettype none

module dcache_ctrl (
   input  wire                         clk,
   input  wire                         rst,
   input  wire                         cpu_req_i,
   input  wire                         cpu_we_i,
   input  wire dcache_pkg::addr_t      cpu_adr_i,
   input  wire dcache_pkg::data_t      cpu_dat_i,
   output logic                        cpu_ack_o,
   output logic                        cpu_err_o,
   output logic                        refill_req_o,
   output dcache_pkg::addr_t           refill_adr_o,
   input  wire                         refill_valid_i,
   input  wire dcache_pkg::data_t      refill_dat_i,
   input  wire                         refill_err_i,
   input  wire                         inv_req_i,
   input  wire dcache_pkg::set_idx_t   inv_set_i,
   output logic                        inv_ack_o,
   output dcache_pkg::set_idx_t        tag_rd_set_o,
   output dcache_pkg::tag_t            tag_cmp_o,
   output logic                        tag_wr_en_o,
   output dcache_pkg::set_idx_t        tag_wr_set_o,
   output dcache_pkg::tag_entry_t      tag_wr_entry_o,
   input  wire dcache_pkg::way_vec_t   hit_way_i,
   input  wire dcache_pkg::tag_entry_t rd_entry_i,
   input  wire dcache_pkg::way_vec_t   victim_way_i,
   input  wire                         init_done_i,
   output logic [dcache_pkg::SET_W+dcache_pkg::WORD_SEL_W-1:0] way_addr_o,
   output dcache_pkg::way_vec_t        way_wr_o,
   output logic                        way_merge_o,
   output dcache_pkg::data_t           way_wr_dat_o
);

   dcache_pkg::ctrl_state_e state_q;
   dcache_pkg::ctrl_state_e state_d;
   // Next refill word
   dcache_pkg::word_sel_t   fill_cnt_q;
   // Way being refilled
   dcache_pkg::way_vec_t    victim_q;
   // Fields of the held CPU address
   dcache_pkg::set_idx_t    cpu_set;
   dcache_pkg::word_sel_t   cpu_word;
   logic                    hit;

   assign cpu_set  = cpu_adr_i[dcache_pkg::BYTE_OFF_W+dcache_pkg::WORD_SEL_W +: dcache_pkg::SET_W];
   assign cpu_word = cpu_adr_i[dcache_pkg::BYTE_OFF_W +: dcache_pkg::WORD_SEL_W];
   assign hit      = |hit_way_i;

   // Tag RAM always reads the CPU set
   assign tag_rd_set_o = cpu_set;
   assign tag_cmp_o    = cpu_adr_i[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];

   // Line base with word and byte bits cleared
   assign refill_adr_o = {cpu_adr_i[dcache_pkg::ADDR_W-1:dcache_pkg::WORD_SEL_W+dcache_pkg::BYTE_OFF_W],
                          {(dcache_pkg::WORD_SEL_W + dcache_pkg::BYTE_OFF_W){1'b0}}};
   assign refill_req_o = (state_q == dcache_pkg::REFILL);

   // Refill walks the line from word 0, otherwise the CPU word
   assign way_addr_o = (state_q == dcache_pkg::REFILL) ? {cpu_set, fill_cnt_q} : {cpu_set, cpu_word};

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q    <= dcache_pkg::IDLE;
         fill_cnt_q <= '0;
         victim_q   <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == dcache_pkg::LOOKUP) begin
            // Start of a possible refill
            fill_cnt_q <= '0;
            victim_q   <= victim_way_i;
         end else if (state_q == dcache_pkg::REFILL && refill_valid_i) begin
            fill_cnt_q <= fill_cnt_q + 1'b1;
         end
      end
   end

   always_comb begin
      state_d        = state_q;
      cpu_ack_o      = 1'b0;
      cpu_err_o      = 1'b0;
      inv_ack_o      = 1'b0;
      tag_wr_en_o    = 1'b0;
      tag_wr_set_o   = cpu_set;
      tag_wr_entry_o = rd_entry_i;
      way_wr_o       = '0;
      way_merge_o    = 1'b0;
      way_wr_dat_o   = cpu_dat_i;
      unique case (state_q)
         dcache_pkg::IDLE: begin
            // Invalidate wins over the CPU
            if (init_done_i) begin
               if (inv_req_i) begin
                  state_d = dcache_pkg::INVALIDATE;
               end else if (cpu_req_i) begin
                  state_d = dcache_pkg::LOOKUP;
               end
            end
         end
         dcache_pkg::LOOKUP: begin
            state_d = dcache_pkg::IDLE;
            if (cpu_we_i) begin
               // Writes ack at once and never allocate
               cpu_ack_o = 1'b1;
               if (hit) begin
                  way_wr_o             = hit_way_i;
                  way_merge_o          = 1'b1;
                  tag_wr_en_o          = 1'b1;
                  tag_wr_entry_o.lru   = hit_way_i[0];
               end
            end else if (hit) begin
               // History now points at the other way
               cpu_ack_o          = 1'b1;
               tag_wr_en_o        = 1'b1;
               tag_wr_entry_o.lru = hit_way_i[0];
            end else begin
               // Drop the victim before its data changes
               tag_wr_en_o          = 1'b1;
               tag_wr_entry_o.valid = rd_entry_i.valid & ~victim_way_i;
               state_d              = dcache_pkg::REFILL;
            end
         end
         dcache_pkg::REFILL: begin
            way_wr_dat_o = refill_dat_i;
            if (refill_err_i) begin
               // Abort and leave the victim invalid
               cpu_err_o = 1'b1;
               state_d   = dcache_pkg::IDLE;
            end else if (refill_valid_i) begin
               way_wr_o = victim_q;
               if (fill_cnt_q == '1) begin
                  // Last word so the line becomes valid
                  tag_wr_en_o = 1'b1;
                  for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                     if (victim_q[w]) begin
                        tag_wr_entry_o.valid[w] = 1'b1;
                        tag_wr_entry_o.tag[w]   = tag_cmp_o;
                     end
                  end
                  tag_wr_entry_o.lru = victim_q[0];
                  state_d            = dcache_pkg::IDLE;
               end
            end
         end
         dcache_pkg::INVALIDATE: begin
            // Whole entry cleared
            inv_ack_o      = 1'b1;
            tag_wr_en_o    = 1'b1;
            tag_wr_set_o   = inv_set_i;
            tag_wr_entry_o = '0;
            state_d        = dcache_pkg::IDLE;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/dcache_dpram.sv
// Contents are undefined after power-up and a read that collides with a write returns old data
`timescale 1ns/100ps
`default_nettype none

module dcache_dpram #(
   parameter int ADDR_BITS = dcache_pkg::SET_W,
   parameter int DATA_BITS = dcache_pkg::DATA_W
) (
   input  wire                 clk,
   input  wire [ADDR_BITS-1:0] waddr_i,
   input  wire                 we_i,
   input  wire [DATA_BITS-1:0] din_i,
   input  wire [ADDR_BITS-1:0] raddr_i,
   output logic [DATA_BITS-1:0] dout_o
);

   // Storage array
   logic [DATA_BITS-1:0] mem [2**ADDR_BITS];

   always_ff @(posedge clk) begin
      // Write port
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
      // Registered read sees the value from before this edge
      dout_o <= mem[raddr_i];
   end

endmodule

`default_nettype wire

//--- hdl/dcache_pkg.sv
// Geometry is fixed at two ways with 16 sets of 16-byte lines and the LRU bit depends on that
`default_nettype none

package dcache_pkg;

   // Address split is tag | set | word | byte
   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int BYTE_OFF_W = 2;
   localparam int WORD_SEL_W = 2;
   localparam int SET_W      = 4;
   localparam int TAG_W      = ADDR_W - SET_W - WORD_SEL_W - BYTE_OFF_W;

   // Only two ways work with a single history bit
   localparam int NUM_WAYS   = 2;

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [DATA_W/8-1:0]   bsel_t;
   typedef logic [TAG_W-1:0]      tag_t;
   typedef logic [SET_W-1:0]      set_idx_t;
   typedef logic [WORD_SEL_W-1:0] word_sel_t;

   // One-hot, bit n is way n
   typedef logic [NUM_WAYS-1:0]   way_vec_t;

   // One tag RAM entry per set
   typedef struct packed {
      // Index of the way used least recently
      logic                lru;
      // Per-way valid flags
      logic [NUM_WAYS-1:0] valid;
      // Per-way stored tags
      tag_t [NUM_WAYS-1:0] tag;
   } tag_entry_t;

   // Controller states
   typedef enum logic [1:0] {
      IDLE,
      LOOKUP,
      REFILL,
      INVALIDATE
   } ctrl_state_e;

endpackage

`default_nettype wire

//--- hdl/dcache_tag_store.sv
// Needs 16 cycles after rst to clear the tags and lookups are meaningless until init_done_o
`timescale 1ns/100ps
`default_nettype none

module dcache_tag_store (
   input  wire                         clk,
   input  wire                         rst,
   input  wire dcache_pkg::set_idx_t   rd_set_i,
   input  wire dcache_pkg::tag_t       cmp_tag_i,
   input  wire                         wr_en_i,
   input  wire dcache_pkg::set_idx_t   wr_set_i,
   input  wire dcache_pkg::tag_entry_t wr_entry_i,
   output dcache_pkg::tag_entry_t      rd_entry_o,
   output dcache_pkg::way_vec_t        hit_way_o,
   output dcache_pkg::way_vec_t        victim_way_o,
   output logic                        init_done_o
);

   // Sweep pointer for the clear after reset
   dcache_pkg::set_idx_t   init_set;

   // RAM write port after the sweep mux
   logic                   ram_we;
   dcache_pkg::set_idx_t   ram_waddr;
   dcache_pkg::tag_entry_t ram_din;

   // Clear sweep walks all sets once
   always_ff @(posedge clk) begin
      if (rst) begin
         init_set    <= '0;
         init_done_o <= 1'b0;
      end else if (!init_done_o) begin
         init_set <= init_set + 1'b1;
         // Last set written on this edge
         if (init_set == '1) begin
            init_done_o <= 1'b1;
         end
      end
   end

   // Sweep owns the write port until it is done
   always_comb begin
      if (init_done_o) begin
         ram_we    = wr_en_i;
         ram_waddr = wr_set_i;
         ram_din   = wr_entry_i;
      end else begin
         ram_we    = 1'b1;
         ram_waddr = init_set;
         ram_din   = '0;
      end
   end

   dcache_dpram #(
      .ADDR_BITS (dcache_pkg::SET_W),
      .DATA_BITS ($bits(dcache_pkg::tag_entry_t))
   ) i_tag_ram (
      .clk     (clk),
      .waddr_i (ram_waddr),
      .we_i    (ram_we),
      .din_i   (ram_din),
      .raddr_i (rd_set_i),
      .dout_o  (rd_entry_o)
   );

   // Per-way compare qualified by valid
   always_comb begin
      hit_way_o = '0;
      for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
         hit_way_o[w] = rd_entry_o.valid[w] && (rd_entry_o.tag[w] == cmp_tag_i);
      end
   end

   // Victim is the way the history bit names
   assign victim_way_o = dcache_pkg::way_vec_t'(1) << rd_entry_o.lru;

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
// Holds off all requests for 16 cycles after rst while the tag RAM is cleared
`timescale 1ns/100ps
`default_nettype none

module dcache_top (
   input  wire                       clk,
   input  wire                       rst,
   // CPU port
   input  wire                       cpu_req_i,
   input  wire                       cpu_we_i,
   input  wire dcache_pkg::addr_t    cpu_adr_i,
   input  wire dcache_pkg::data_t    cpu_dat_i,
   input  wire dcache_pkg::bsel_t    cpu_bsel_i,
   output logic                      cpu_ack_o,
   output logic                      cpu_err_o,
   output dcache_pkg::data_t         cpu_dat_o,
   // Refill port
   output logic                      refill_req_o,
   output dcache_pkg::addr_t         refill_adr_o,
   input  wire                       refill_valid_i,
   input  wire dcache_pkg::data_t    refill_dat_i,
   input  wire                       refill_err_i,
   // Invalidate port
   input  wire                       inv_req_i,
   input  wire dcache_pkg::set_idx_t inv_set_i,
   output logic                      inv_ack_o
);

   // Tag store request and result
   dcache_pkg::set_idx_t   tag_rd_set;
   dcache_pkg::tag_t       tag_cmp;
   logic                   tag_wr_en;
   dcache_pkg::set_idx_t   tag_wr_set;
   dcache_pkg::tag_entry_t tag_wr_entry;
   dcache_pkg::tag_entry_t rd_entry;
   dcache_pkg::way_vec_t   hit_way;
   dcache_pkg::way_vec_t   victim_way;
   logic                   init_done;

   // Way store control
   logic [dcache_pkg::SET_W+dcache_pkg::WORD_SEL_W-1:0] way_addr;
   dcache_pkg::way_vec_t   way_wr;
   logic                   way_merge;
   dcache_pkg::data_t      way_wr_dat;

   dcache_ctrl i_dcache_ctrl (
      .clk            (clk),
      .rst            (rst),
      .cpu_req_i      (cpu_req_i),
      .cpu_we_i       (cpu_we_i),
      .cpu_adr_i      (cpu_adr_i),
      .cpu_dat_i      (cpu_dat_i),
      .cpu_ack_o      (cpu_ack_o),
      .cpu_err_o      (cpu_err_o),
      .refill_req_o   (refill_req_o),
      .refill_adr_o   (refill_adr_o),
      .refill_valid_i (refill_valid_i),
      .refill_dat_i   (refill_dat_i),
      .refill_err_i   (refill_err_i),
      .inv_req_i      (inv_req_i),
      .inv_set_i      (inv_set_i),
      .inv_ack_o      (inv_ack_o),
      .tag_rd_set_o   (tag_rd_set),
      .tag_cmp_o      (tag_cmp),
      .tag_wr_en_o    (tag_wr_en),
      .tag_wr_set_o   (tag_wr_set),
      .tag_wr_entry_o (tag_wr_entry),
      .hit_way_i      (hit_way),
      .rd_entry_i     (rd_entry),
      .victim_way_i   (victim_way),
      .init_done_i    (init_done),
      .way_addr_o     (way_addr),
      .way_wr_o       (way_wr),
      .way_merge_o    (way_merge),
      .way_wr_dat_o   (way_wr_dat)
   );

   dcache_tag_store i_dcache_tag_store (
      .clk          (clk),
      .rst          (rst),
      .rd_set_i     (tag_rd_set),
      .cmp_tag_i    (tag_cmp),
      .wr_en_i      (tag_wr_en),
      .wr_set_i     (tag_wr_set),
      .wr_entry_i   (tag_wr_entry),
      .rd_entry_o   (rd_entry),
      .hit_way_o    (hit_way),
      .victim_way_o (victim_way),
      .init_done_o  (init_done)
   );

   // Hit vector selects the read word and the merge source
   dcache_way_store i_dcache_way_store (
      .clk        (clk),
      .rd_addr_i  (way_addr),
      .wr_addr_i  (way_addr),
      .wr_way_i   (way_wr),
      .wr_merge_i (way_merge),
      .wr_dat_i   (way_wr_dat),
      .wr_bsel_i  (cpu_bsel_i),
      .sel_way_i  (hit_way),
      .rd_dat_o   (cpu_dat_o)
   );

endmodule

`default_nettype wire

//--- hdl/dcache_way_store.sv
// Read data lags the address by one cycle and a merged write takes old bytes from that read data
`timescale 1ns/100ps
`default_nettype none

module dcache_way_store (
   input  wire                                                    clk,
   input  wire [dcache_pkg::SET_W+dcache_pkg::WORD_SEL_W-1:0]    rd_addr_i,
   input  wire [dcache_pkg::SET_W+dcache_pkg::WORD_SEL_W-1:0]    wr_addr_i,
   input  wire dcache_pkg::way_vec_t                              wr_way_i,
   input  wire                                                    wr_merge_i,
   input  wire dcache_pkg::data_t                                 wr_dat_i,
   input  wire dcache_pkg::bsel_t                                 wr_bsel_i,
   input  wire dcache_pkg::way_vec_t                              sel_way_i,
   output dcache_pkg::data_t                                      rd_dat_o
);

   // Raw read data of each way
   dcache_pkg::data_t way_dout [dcache_pkg::NUM_WAYS];

   // Word that goes into the RAM
   dcache_pkg::data_t merged;

   // One data RAM per way
   for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_way
      dcache_dpram #(
         .ADDR_BITS (dcache_pkg::SET_W + dcache_pkg::WORD_SEL_W),
         .DATA_BITS (dcache_pkg::DATA_W)
      ) i_data_ram (
         .clk     (clk),
         .waddr_i (wr_addr_i),
         .we_i    (wr_way_i[w]),
         .din_i   (merged),
         .raddr_i (rd_addr_i),
         .dout_o  (way_dout[w])
      );
   end

   // Output mux on the one-hot way select
   always_comb begin
      rd_dat_o = '0;
      for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
         if (sel_way_i[w]) begin
            rd_dat_o = way_dout[w];
         end
      end
   end

   // Byte lane merge
   // Unselected lanes keep the cached byte
   always_comb begin
      merged = wr_dat_i;
      if (wr_merge_i) begin
         for (int b = 0; b < dcache_pkg::DATA_W / 8; b++) begin
            if (!wr_bsel_i[b]) begin
               merged[8*b +: 8] = rd_dat_o[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire
